/* verilog.f */
logic/arrayHeapPkg.sv
logic/apbCommandPort.sv
logic/heapAllocator.sv
logic/arrayStore.sv
logic/arraySearch.sv
logic/arrayHeapTop.sv
dv/arrayHeap_props.sv
dv/arrayHeapTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = arrayHeapTb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* dv/arrayHeapTb.sv */
//----------------------------
// Array heap testbench with clock, reset, APB tasks,
// stimulus table, checks, watchdog and summary
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb;
  import arrayHeapPkg::*;

  localparam int arrayBits   = 2;
  localparam int indexBits   = 3;
  localparam int dataBits    = 12;
  localparam int slots       = 2**indexBits;
  localparam int clockPeriod = 10;
  localparam int resetCycles = 8;
  localparam int waitLimit   = slots + 8;         // Cycles allowed per transfer

  typedef struct packed {
    logic [3:0]  addr;
    logic        write;
    logic [31:0] wdata;
    logic [31:0] expData;                         // Checked on reads only
    logic        expErr;
  } tableRow;

  logic        clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  tableRow rows[$];
  string   notes[$];
  bit      tableReady;
  int      passCount;
  int      failCount;

  arrayHeapTop #(
    .arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)
  ) arrayHeapTop_inst (
    .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  //----------------------------
  // APB master
  //----------------------------
  // Access phase and wait for PREADY at the falling edge
  task automatic waitReady(output logic [31:0] rdata, output logic err, output logic stuck);
    int waits;
    waits = 0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    @(negedge clock);
    while (!pready && waits < waitLimit) begin
      @(negedge clock);
      waits++;
    end
    stuck = !pready;
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data,
                          output logic err, output logic stuck);
    logic [31:0] ignored;
    psel    = 1'b1;                               // Setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    waitReady(ignored, err, stuck);
  endtask

  task automatic apbRead(input logic [3:0] addr, output logic [31:0] rdata,
                         output logic err, output logic stuck);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    waitReady(rdata, err, stuck);
  endtask

  //----------------------------
  // Table building
  //----------------------------
  function automatic logic [31:0] cmdWord(heapAction action, int arr, int idx);
    heapCommand c;
    c.action = action;
    c.array  = 8'(arr);
    c.index  = 8'(idx);
    return {12'd0, c};
  endfunction

  // Reference rules for the three searches over the first count values
  function automatic int scanModel(heapAction action, int values[slots], int count, int key);
    int answer;
    answer = 0;
    for (int i = 0; i < count; i++) begin
      if (action == opIndex && values[i] == key) answer = i + 1;  // Last match wins
      if (action == opLess && values[i] < key) answer++;
      if (action == opGreater && values[i] > key) answer++;
    end
    return answer;
  endfunction

  task automatic addRow(logic [3:0] addr, logic write, logic [31:0] wdata,
                        logic [31:0] expData, logic expErr, string note);
    tableRow r;
    r.addr    = addr;
    r.write   = write;
    r.wdata   = wdata;
    r.expData = expData;
    r.expErr  = expErr;
    rows.push_back(r);
    notes.push_back(note);
  endtask

  task automatic setData(int value);
    addRow(regData, 1'b1, value, 32'd0, 1'b0, $sformatf("DATA = %0d", value));
  endtask

  task automatic issue(heapAction action, int arr, int idx, logic expErr, string note);
    addRow(regCmd, 1'b1, cmdWord(action, arr, idx), 32'd0, expErr, note);
  endtask

  task automatic expectResult(int value, string note);
    addRow(regResult, 1'b0, 32'd0, value, 1'b0, note);
  endtask

  task automatic expectStatus(heapError code, string note);
    addRow(regStatus, 1'b0, 32'd0, 32'(code), 1'b0, note);
  endtask

  task automatic searchRow(heapAction action, int arr, int key, int expected);
    setData(key);
    issue(action, arr, 0, 1'b0, $sformatf("%s key %0d", action.name(), key));
    expectResult(expected, $sformatf("%s result", action.name()));
  endtask

  task automatic buildTable();
    int keys[4]        = '{30, 20, 10, 15};
    int indexExpect[4] = '{3, 2, 1, 0};          // Position plus one, zero when absent
    int bounds[4]      = '{35, 25, 15, 5};
    int values[slots];
    int count;
    int key;
    // Allocation and reuse
    issue(opReset, 0, 0, 1'b0, "heap reset");
    for (int i = 0; i < 4; i++) begin
      issue(opAlloc, 0, 0, 1'b0, "alloc");
      expectResult(i, $sformatf("alloc gives %0d", i));
    end
    issue(opAlloc, 0, 0, 1'b1, "alloc with none left");
    expectStatus(errOutOfMemory, "out of memory code");
    issue(opFree, 2, 0, 1'b0, "free array 2");
    issue(opAlloc, 0, 0, 1'b0, "alloc after free");
    expectResult(2, "freed array reused");
    // Write, size and read on array 0
    for (int i = 0; i < 3; i++) begin
      setData(10 * (i + 1));
      issue(opWrite, 0, i, 1'b0, $sformatf("write index %0d", i));
    end
    issue(opSize, 0, 0, 1'b0, "size");
    expectResult(3, "size after writes");
    for (int i = 0; i < 3; i++) begin
      issue(opRead, 0, i, 1'b0, $sformatf("read index %0d", i));
      expectResult(10 * (i + 1), "read value");
    end
    issue(opRead, 0, 3, 1'b1, "read past size");
    expectStatus(errOutOfBounds, "out of bounds code");
    // Push to full, then pop to empty on array 1
    for (int i = 0; i < slots; i++) begin
      setData(100 + i);
      issue(opPush, 1, 0, 1'b0, "push");
    end
    setData(999);
    issue(opPush, 1, 0, 1'b1, "push on full");
    expectStatus(errFull, "full code");
    for (int i = slots - 1; i >= 0; i--) begin
      issue(opPop, 1, 0, 1'b0, "pop");
      expectResult(100 + i, "popped value");
    end
    issue(opPop, 1, 0, 1'b1, "pop on empty");
    expectStatus(errEmpty, "empty code");
    // Fixed searches on 10, 20, 30
    for (int i = 0; i < 4; i++) searchRow(opIndex, 0, keys[i], indexExpect[i]);
    for (int i = 0; i < 4; i++) searchRow(opLess, 0, bounds[i], 3 - i);
    for (int i = 0; i < 4; i++) searchRow(opGreater, 0, bounds[i], i);
    // Random contents in array 2
    count = 3 + int'($urandom % 6);
    for (int i = 0; i < slots; i++) values[i] = 0;
    for (int i = 0; i < count; i++) begin
      values[i] = int'($urandom % 16);
      setData(values[i]);
      issue(opWrite, 2, i, 1'b0, $sformatf("random write index %0d", i));
    end
    issue(opSize, 2, 0, 1'b0, "size");
    expectResult(count, "random size");
    for (int k = 0; k < 4; k++) begin
      key = int'($urandom % 16);
      searchRow(opIndex, 2, key, scanModel(opIndex, values, count, key));
      searchRow(opLess, 2, key, scanModel(opLess, values, count, key));
      searchRow(opGreater, 2, key, scanModel(opGreater, values, count, key));
    end
    // Freed and never allocated arrays
    issue(opFree, 3, 0, 1'b0, "free array 3");
    issue(opRead, 3, 0, 1'b1, "read freed");
    expectStatus(errNotAllocated, "not allocated code");
    setData(5);
    issue(opWrite, 3, 0, 1'b1, "write freed");
    expectStatus(errNotAllocated, "not allocated code");
    issue(opIndex, 3, 0, 1'b1, "search freed");
    expectStatus(errNotAllocated, "not allocated code");
    issue(opFree, 3, 0, 1'b1, "double free");
    issue(opReset, 0, 0, 1'b0, "heap reset");
    issue(opRead, 0, 0, 1'b1, "read never allocated");
    expectStatus(errNotAllocated, "not allocated code");
    issue(opLess, 1, 0, 1'b1, "search never allocated");
    expectStatus(errNotAllocated, "not allocated code");
  endtask

  //----------------------------
  // Main sequence
  //----------------------------
  initial begin
    tableRow     row;
    logic [31:0] rdata;
    logic        err;
    logic        stuck;
    bit          rowFailed;
    reset   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rdata   = '0;
    void'($urandom(45640));
    buildTable();
    tableReady = 1'b1;
    repeat (resetCycles) @(posedge clock);
    #1;
    reset = 1'b1;
    @(posedge clock);
    #1;
    foreach (rows[i]) begin
      row       = rows[i];
      rowFailed = 1'b0;
      if (row.write) apbWrite(row.addr, row.wdata, err, stuck);
      else apbRead(row.addr, rdata, err, stuck);
      if (stuck) begin
        $display("Row %0d (%s): PREADY never came back", i, notes[i]);
        rowFailed = 1'b1;
      end else begin
        assert (err === row.expErr) else begin
          $display("MISMATCH row %0d pslverr expected %h got %h", i, row.expErr, err);
          rowFailed = 1'b1;
        end
        if (!row.write) begin
          assert (rdata === row.expData) else begin
            $display("MISMATCH row %0d prdata expected %h got %h", i, row.expData, rdata);
            rowFailed = 1'b1;
          end
        end
      end
      if (rowFailed) failCount++;
      else passCount++;
      $display("Row %0d %s addr %h %s", i, notes[i], row.addr, rowFailed ? "bad" : "ok");
    end
    $display("Summary: %0d rows, %0d passed, %0d failed", rows.size(), passCount, failCount);
    if (failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Worst case per row is one full scan plus the APB phases
  initial begin
    longint watchLimit;
    wait (tableReady);
    watchLimit = longint'((rows.size() * (slots + 4) + resetCycles + 10) * clockPeriod * 2);
    #(watchLimit);
    $display("Watchdog expired after %0d ns, run did not finish", watchLimit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/arrayHeap_props.sv */
//----------------------------
// APB protocol and completion checks,
// bound into the command port
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapProps #(
  parameter int indexBits = 3
) (
  input logic       clock,
  input logic       reset,
  input logic       psel,
  input logic       penable,
  input logic [3:0] paddr,
  input logic       pready,
  input logic       pslverr,
  input logic       start,
  input logic       done
);
  localparam int maxWait = 2**indexBits + 2;      // Longest search plus slack

  logic [7:0] waitCount;                          // Cycles since start, zero when idle

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      waitCount <= '0;
    end else if (start) begin
      waitCount <= 8'd1;
    end else if (done) begin
      waitCount <= '0;
    end else if (waitCount != '0) begin
      waitCount <= waitCount + 8'd1;
    end
  end

  errOnlyWithReady: assert property (@(posedge clock) disable iff (!reset)
    pslverr |-> pready)
    else $error("PSLVERR high without PREADY");

  stableWhileWaiting: assert property (@(posedge clock) disable iff (!reset)
    (psel && penable && !pready) |=> (psel && $stable(paddr)))
    else $error("PSEL or PADDR changed during a wait state");

  doneInTime: assert property (@(posedge clock) disable iff (!reset)
    waitCount <= 8'(maxWait))
    else $error("Unit did not answer the start pulse in time");

endmodule

bind apbCommandPort arrayHeapProps apbProps (
  .clock(clock), .reset(reset), .psel(psel), .penable(penable), .paddr(paddr),
  .pready(pready), .pslverr(pslverr), .start(start), .done(done)
);

`default_nettype wire

/* logic/arrayHeapTop.sv */
//----------------------------
// Array heap top level: APB port plus allocator,
// store and search units
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTop #(
  parameter int arrayBits = 2,
  parameter int indexBits = 3,
  parameter int dataBits  = 12
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import arrayHeapPkg::*;

  logic                   start;
  heapCommand             command;
  logic [dataBits-1:0]    operand;
  logic                   done;
  logic [dataBits-1:0]    result;
  heapError               status;
  logic                   allocDone, storeDone, searchDone;
  logic [dataBits-1:0]    allocResult, storeResult, searchResult;
  heapError               allocStatus, storeStatus, searchStatus;
  logic [2**arrayBits-1:0] allocated;
  logic                   clearSize;
  logic [arrayBits-1:0]   clearArray;
  logic [arrayBits-1:0]   scanArray;
  logic [indexBits-1:0]   scanIndex;
  logic [dataBits-1:0]    scanElement;
  logic [indexBits:0]     scanSize;

  // One unit answers per command, idle ones drive zero
  assign done   = allocDone | storeDone | searchDone;
  assign result = allocResult | storeResult | searchResult;
  assign status = heapError'(allocStatus | storeStatus | searchStatus);

  apbCommandPort #(.dataBits(dataBits)) port (
    .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .start, .command, .operand, .done, .result, .status
  );

  heapAllocator #(.arrayBits(arrayBits), .dataBits(dataBits)) allocator (
    .clock, .reset, .start, .command,
    .done(allocDone), .result(allocResult), .status(allocStatus),
    .allocated, .clearSize, .clearArray
  );

  arrayStore #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) store (
    .clock, .reset, .start, .command, .operand, .allocated, .clearSize, .clearArray,
    .done(storeDone), .result(storeResult), .status(storeStatus),
    .scanArray, .scanIndex, .scanElement, .scanSize
  );

  arraySearch #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) search (
    .clock, .reset, .start, .command, .operand, .allocated,
    .scanArray, .scanIndex, .scanElement, .scanSize,
    .done(searchDone), .result(searchResult), .status(searchStatus)
  );

endmodule

`default_nettype wire

/* logic/arraySearch.sv */
//----------------------------
// Serial scan of one array: index-of, count-less
// and count-greater, one slot per cycle
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module arraySearch #(
  parameter int arrayBits = 2,
  parameter int indexBits = 3,
  parameter int dataBits  = 12
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  arrayHeapPkg::heapCommand command,
  input  logic [dataBits-1:0]      operand,
  input  logic [2**arrayBits-1:0]  allocated,
  output logic [arrayBits-1:0]     scanArray,
  output logic [indexBits-1:0]     scanIndex,
  input  logic [dataBits-1:0]      scanElement,
  input  logic [indexBits:0]       scanSize,
  output logic                     done,
  output logic [dataBits-1:0]      result,
  output arrayHeapPkg::heapError   status
);
  import arrayHeapPkg::*;

  logic               scanning;
  logic [indexBits:0] count;                      // Match count or position
  logic [indexBits:0] countNext;
  logic               hit;
  logic               mine;
  logic               lastSlot;

  assign scanArray = command.array[arrayBits-1:0];
  assign mine      = start && (command.action inside {opIndex, opLess, opGreater});
  assign lastSlot  = &scanIndex;

  always_comb begin
    case (command.action)
      opIndex:   hit = scanElement == operand;
      opLess:    hit = scanElement < operand;
      opGreater: hit = scanElement > operand;
      default:   hit = 1'b0;
    endcase
    countNext = count;
    if (scanning && ({1'b0, scanIndex} < scanSize) && hit) begin  // Slots past the size ignored
      countNext = (command.action == opIndex) ? {1'b0, scanIndex} + 1'b1 : count + 1'b1;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      scanning  <= 1'b0;
      scanIndex <= '0;
      count     <= '0;
      done      <= 1'b0;
      result    <= '0;
      status    <= errNone;
    end else begin
      done   <= 1'b0;
      result <= '0;
      status <= errNone;
      if (mine) begin
        if (!allocated[scanArray]) begin
          done   <= 1'b1;                         // Fails before any scan
          status <= errNotAllocated;
        end else begin
          scanning  <= 1'b1;
          scanIndex <= '0;
          count     <= '0;
        end
      end else if (scanning) begin
        count     <= countNext;
        scanIndex <= scanIndex + 1'b1;
        if (lastSlot) begin
          scanning <= 1'b0;
          done     <= 1'b1;
          result   <= dataBits'(countNext);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/arrayStore.sv */
//----------------------------
// Element memory and per-array sizes: write, read,
// size, push, pop, plus a read port for the scanner
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayStore #(
  parameter int arrayBits = 2,
  parameter int indexBits = 3,
  parameter int dataBits  = 12
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  arrayHeapPkg::heapCommand command,
  input  logic [dataBits-1:0]      operand,
  input  logic [2**arrayBits-1:0]  allocated,
  input  logic                     clearSize,
  input  logic [arrayBits-1:0]     clearArray,
  output logic                     done,
  output logic [dataBits-1:0]      result,
  output arrayHeapPkg::heapError   status,
  input  logic [arrayBits-1:0]     scanArray,
  input  logic [indexBits-1:0]     scanIndex,
  output logic [dataBits-1:0]      scanElement,
  output logic [indexBits:0]       scanSize
);
  import arrayHeapPkg::*;

  localparam int arrays = 2**arrayBits;
  localparam int slots  = 2**indexBits;

  logic [dataBits-1:0]            memory [arrays*slots];  // Fixed block per array
  logic [indexBits:0]             sizes  [arrays];
  logic [arrayBits-1:0]           arr;
  logic [indexBits-1:0]           idx;
  logic [indexBits:0]             curSize;
  logic [indexBits-1:0]           topSlot;
  logic                           mine;
  logic                           live;
  logic                           full;
  logic                           memWrite;
  logic [arrayBits+indexBits-1:0] memAddr;

  assign arr     = command.array[arrayBits-1:0];
  assign idx     = command.index[indexBits-1:0];
  assign curSize = sizes[arr];
  assign topSlot = curSize[indexBits-1:0] - 1'b1; // Last element, for pop
  assign full    = curSize[indexBits];
  assign live    = allocated[arr];
  assign mine    = start && (command.action inside {opWrite, opRead, opSize, opPush, opPop});

  assign memWrite = mine && live &&
                    ((command.action == opWrite) || ((command.action == opPush) && !full));
  assign memAddr  = (command.action == opPush) ? {arr, curSize[indexBits-1:0]} : {arr, idx};

  // Scanner read port, independent of the command path
  assign scanElement = memory[{scanArray, scanIndex}];
  assign scanSize    = sizes[scanArray];

  always_ff @(posedge clock) begin
    if (memWrite) begin
      memory[memAddr] <= operand;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int a = 0; a < arrays; a++) begin
        sizes[a] <= '0;
      end
      done   <= 1'b0;
      result <= '0;
      status <= errNone;
    end else begin
      done   <= mine;
      result <= '0;
      status <= errNone;
      if (clearSize) begin
        sizes[clearArray] <= '0;                  // Fresh allocation
      end
      if (mine && !live) begin
        status <= errNotAllocated;
      end else if (mine) begin
        case (command.action)
          opWrite: begin
            if ({1'b0, idx} >= curSize) begin
              sizes[arr] <= {1'b0, idx} + 1'b1;   // Write past the end grows it
            end
            result <= operand;
          end
          opRead: begin
            if ({1'b0, idx} < curSize) begin
              result <= memory[{arr, idx}];
            end else begin
              status <= errOutOfBounds;
            end
          end
          opSize: result <= dataBits'(curSize);
          opPush: begin
            if (!full) begin
              sizes[arr] <= curSize + 1'b1;
              result     <= operand;
            end else begin
              status <= errFull;
            end
          end
          opPop: begin
            if (curSize != '0) begin
              sizes[arr] <= curSize - 1'b1;
              result     <= memory[{arr, topSlot}];
            end else begin
              status <= errEmpty;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* logic/heapAllocator.sv */
//----------------------------
// Array allocator: allocation flags, freed-array
// stack and count of fresh arrays handed out
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module heapAllocator #(
  parameter int arrayBits = 2,
  parameter int dataBits  = 12
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  arrayHeapPkg::heapCommand command,
  output logic                     done,
  output logic [dataBits-1:0]      result,
  output arrayHeapPkg::heapError   status,
  output logic [2**arrayBits-1:0]  allocated,
  output logic                     clearSize,
  output logic [arrayBits-1:0]     clearArray
);
  import arrayHeapPkg::*;

  localparam int arrays = 2**arrayBits;

  logic [arrayBits-1:0] freedStack [arrays];
  logic [arrayBits:0]   freedTop;                 // Entries on the stack
  logic [arrayBits:0]   nextFresh;                // Next never-used array
  logic [arrayBits-1:0] target;
  logic [arrayBits-1:0] grant;
  logic                 mine;
  logic                 reuse;
  logic                 fresh;
  logic                 freeOk;

  assign target = command.array[arrayBits-1:0];
  assign mine   = start && (command.action inside {opReset, opAlloc, opFree});
  assign reuse  = freedTop != '0;
  assign fresh  = !nextFresh[arrayBits];          // Top bit set once all used
  assign grant  = reuse ? freedStack[freedTop[arrayBits-1:0] - 1'b1]
                        : nextFresh[arrayBits-1:0];
  assign freeOk = mine && (command.action == opFree) && allocated[target];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      freedTop   <= '0;
      nextFresh  <= '0;
      done       <= 1'b0;
      result     <= '0;
      status     <= errNone;
      clearSize  <= 1'b0;
      clearArray <= '0;
    end else begin
      done      <= mine;
      result    <= '0;                            // Idle outputs stay zero for the OR
      status    <= errNone;
      clearSize <= 1'b0;
      if (mine) begin
        case (command.action)
          opReset: begin
            allocated <= '0;
            freedTop  <= '0;
            nextFresh <= '0;
          end
          opAlloc: begin
            if (reuse || fresh) begin
              allocated[grant] <= 1'b1;
              result           <= dataBits'(grant);
              clearSize        <= 1'b1;           // New array starts empty
              clearArray       <= grant;
              if (reuse) begin
                freedTop <= freedTop - 1'b1;
              end else begin
                nextFresh <= nextFresh + 1'b1;
              end
            end else begin
              status <= errOutOfMemory;
            end
          end
          opFree: begin
            if (freeOk) begin
              allocated[target] <= 1'b0;
              freedTop          <= freedTop + 1'b1;
            end else begin
              status <= errNotAllocated;          // Also catches a double free
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (freeOk) begin
      freedStack[freedTop[arrayBits-1:0]] <= target;
    end
  end

endmodule

`default_nettype wire

/* logic/apbCommandPort.sv */
//----------------------------
// APB slave for the array heap: DATA, CMD, RESULT and
// STATUS registers, start pulse and wait states
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module apbCommandPort #(
  parameter int dataBits = 12
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [3:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     start,
  output arrayHeapPkg::heapCommand command,
  output logic [dataBits-1:0]      operand,
  input  logic                     done,
  input  logic [dataBits-1:0]      result,
  input  arrayHeapPkg::heapError   status
);
  import arrayHeapPkg::*;

  localparam int cmdBits = $bits(heapCommand);

  logic                access;
  logic                cmdAccess;
  logic                busy;                      // Operation in flight
  heapCommand          incoming;
  heapCommand          cmdLatch;
  logic [dataBits-1:0] dataReg;
  logic [dataBits-1:0] resultReg;
  heapError            statusReg;

  assign access    = psel && penable;
  assign cmdAccess = access && pwrite && (paddr == regCmd);
  assign incoming  = heapCommand'(pwdata[cmdBits-1:0]);

  // First access cycle of a CMD write fires the unit
  assign start   = cmdAccess && !busy;
  assign command = start ? incoming : cmdLatch;   // Held for the whole scan
  assign operand = dataReg;

  // Wait states only on CMD writes, released by the unit's done
  assign pready  = !cmdAccess || (busy && done);
  assign pslverr = cmdAccess && busy && done && (status != errNone);

  always_comb begin
    case (paddr)
      regData:   prdata = 32'(dataReg);
      regCmd:    prdata = {{(32-cmdBits){1'b0}}, cmdLatch};
      regResult: prdata = 32'(resultReg);
      regStatus: prdata = 32'(statusReg);
      default:   prdata = '0;
    endcase
  end

  //----------------------------
  // Control state
  //----------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy      <= 1'b0;
      cmdLatch  <= '0;
      statusReg <= errNone;
    end else begin
      if (start) begin
        busy     <= 1'b1;
        cmdLatch <= incoming;
      end else if (done) begin
        busy      <= 1'b0;
        statusReg <= status;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access && pwrite && (paddr == regData)) begin
      dataReg <= pwdata[dataBits-1:0];
    end
    if (done) begin
      resultReg <= result;
    end
  end

endmodule

`default_nettype wire

/* logic/arrayHeapPkg.sv */
//----------------------------
// Array heap shared definitions: opcodes, error codes,
// command word layout and APB register map
//----------------------------
`default_nettype none

package arrayHeapPkg;

  localparam int maxArrayBits = 8;                // Widest array number field
  localparam int maxIndexBits = 8;                // Widest element index field

  //----------------------------
  // Operations
  //----------------------------
  typedef enum logic [3:0] {
    opReset   = 4'd0,                             // Forget every array
    opAlloc   = 4'd1,                             // Hand out an array number
    opFree    = 4'd2,                             // Return an array for reuse
    opWrite   = 4'd3,                             // Store element, may grow array
    opRead    = 4'd4,                             // Bounds-checked element read
    opSize    = 4'd5,                             // Current element count
    opPush    = 4'd6,                             // Append at the end
    opPop     = 4'd7,                             // Remove from the end
    opIndex   = 4'd8,                             // Last match position plus one
    opLess    = 4'd9,                             // Count of smaller elements
    opGreater = 4'd10                             // Count of larger elements
  } heapAction;

  // Zero must stay errNone, the unit outputs are merged by OR
  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                       // Array not currently held
    errOutOfBounds  = 4'd2,                       // Index at or past the size
    errFull         = 4'd3,                       // Push onto a full array
    errEmpty        = 4'd4,                       // Pop from an empty array
    errOutOfMemory  = 4'd5                        // No array left to hand out
  } heapError;

  // CMD register layout, also the word sent to each unit
  typedef struct packed {
    heapAction               action;              // Bits 19:16
    logic [maxArrayBits-1:0] array;               // Bits 15:8
    logic [maxIndexBits-1:0] index;               // Bits 7:0
  } heapCommand;

  //----------------------------
  // APB byte addresses
  //----------------------------
  localparam logic [3:0] regData   = 4'd0;        // Operand
  localparam logic [3:0] regCmd    = 4'd4;        // Write starts an operation
  localparam logic [3:0] regResult = 4'd8;        // Last result
  localparam logic [3:0] regStatus = 4'd12;       // Last error code

endpackage

`default_nettype wire
